//--- bus_pkg.sv
// Types of the host peripheral bus between the core and the wrapper
`include "periph_defines.svh"

package bus_pkg;

    // Peripheral address from the core
    typedef logic [`PERI_ADDR_W-1:0] addr_t;

    typedef logic [`PERI_DATA_W-1:0] data_t;

    // 11 none, 00 byte, 01 halfword, 10 word
    typedef logic [1:0] acc_t;

    typedef logic [$clog2(`PERI_NUM_SLOTS)-1:0] slot_t;
    typedef logic [`PERI_NUM_SLOTS-1:0] slot_sel_t;

    // Register offset inside one 64-byte user window
    typedef logic [`PERI_USER_SLOT_LSB-1:0] reg_ofs_t;

endpackage

//--- gpio_pkg.sv
// Types of the GPIO pins and their output function selects
`include "periph_defines.svh"

package gpio_pkg;

    // One bit per PMOD pin
    typedef logic [`GPIO_NUM_PINS-1:0] pins_t;

    // Bit 4 picks the simple space, bits 3:0 the slot in that space
    typedef logic [`GPIO_FSEL_W-1:0] fsel_t;

endpackage

//--- gpio_regs.sv
// GPIO block with output register, input readback and per-pin function selects
`include "periph_defines.svh"

module gpio_regs
    import bus_pkg::*;
    import gpio_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  reg_ofs_t i_ofs,
    input  data_t    i_wdata,
    input  acc_t     i_write_n,
    input  pins_t    i_ui_in,
    output data_t    o_rdata,
    output pins_t    o_uo_out
);

    localparam int PIN_IDX_W = $clog2(`GPIO_NUM_PINS);

    // Select value that routes a pin to this block's output register
    localparam fsel_t FSEL_GPIO = fsel_t'(`PERI_SLOT_GPIO);
    localparam fsel_t FSEL_UART = fsel_t'(`PERI_SLOT_UART);

    pins_t                gpio_out_q;
    fsel_t                fsel_q [`GPIO_NUM_PINS];
    logic                 wr_en;
    logic                 fsel_hit;
    logic [PIN_IDX_W-1:0] pin_idx;

    assign wr_en = (i_write_n != `ACC_NONE);

    // Word-aligned accesses in the upper half of the window
    assign fsel_hit = i_ofs[`GPIO_FSEL_BASE_BIT] && (i_ofs[1:0] == 2'b00);
    assign pin_idx  = i_ofs[2 +: PIN_IDX_W];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gpio_out_q <= '0;
        end else if (wr_en && i_ofs == `GPIO_OFS_OUT) begin
            gpio_out_q <= i_wdata[`GPIO_NUM_PINS-1:0];
        end
    end

    // Pins 0 and 1 come out of reset on the old UART slot
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `GPIO_NUM_PINS; i++) begin
                fsel_q[i] <= (i < 2) ? FSEL_UART : FSEL_GPIO;
            end
        end else if (wr_en && fsel_hit) begin
            fsel_q[pin_idx] <= i_wdata[`GPIO_FSEL_W-1:0];
        end
    end

    // Read mux, unused offsets return zero
    always_comb begin
        o_rdata = '0;
        if (i_ofs == `GPIO_OFS_OUT) begin
            o_rdata[`GPIO_NUM_PINS-1:0] = gpio_out_q;
        end else if (i_ofs == `GPIO_OFS_IN) begin
            o_rdata[`GPIO_NUM_PINS-1:0] = i_ui_in;
        end else if (fsel_hit) begin
            o_rdata[`GPIO_FSEL_W-1:0] = fsel_q[pin_idx];
        end
    end

    // Any source other than user slot 1 is absent and drives low
    always_comb begin
        for (int i = 0; i < `GPIO_NUM_PINS; i++) begin
            o_uo_out[i] = (fsel_q[i] == FSEL_GPIO) ? gpio_out_q[i] : 1'b0;
        end
    end

endmodule

//--- periph_decode.sv
// Address decoder that selects a user slot and muxes read data and ready
`include "periph_defines.svh"

module periph_decode
    import bus_pkg::*;
(
    input  addr_t     i_addr,
    input  data_t     i_gpio_rdata,
    output slot_sel_t o_user_sel,
    output data_t     o_rdata_src,
    output logic      o_ready_src
);

    logic  simple_space;
    slot_t user_slot;
    logic  gpio_hit;

    assign simple_space = i_addr[`PERI_SIMPLE_BIT];
    assign user_slot    = i_addr[`PERI_USER_SLOT_LSB +: $bits(slot_t)];

    // One-hot select, all clear while the simple space is addressed
    always_comb begin
        o_user_sel = '0;
        if (!simple_space) begin
            o_user_sel[user_slot] = 1'b1;
        end
    end

    assign gpio_hit = o_user_sel[`PERI_SLOT_GPIO];

    // Only the GPIO slot is populated, every other slot reads as zero
    always_comb begin
        o_rdata_src = '0;
        if (gpio_hit) begin
            o_rdata_src = i_gpio_rdata;
        end
    end

    // GPIO and the empty slots all answer in the same cycle
    assign o_ready_src = 1'b1;

endmodule

//--- periph_defines.svh
// Address map, GPIO register layout and reset values for the peripheral wrapper
`ifndef PERIPH_DEFINES_SVH
`define PERIPH_DEFINES_SVH

// Host bus widths
`define PERI_ADDR_W 11
`define PERI_DATA_W 32

// Address bit 10 selects the simple space
`define PERI_SIMPLE_BIT 10
// User slots are 64-byte windows in bits 9:6
`define PERI_USER_SLOT_LSB 6
// Simple slots are 16-byte windows in bits 7:4
`define PERI_SIMPLE_SLOT_LSB 4
`define PERI_NUM_SLOTS 16

// Slot numbers within the user space
`define PERI_SLOT_GPIO 1
`define PERI_SLOT_UART 2

// GPIO block
`define GPIO_NUM_PINS 8
`define GPIO_OFS_OUT 6'h00
`define GPIO_OFS_IN 6'h04
// Function select bank at 0x20..0x3c, pin index in offset bits 4:2
`define GPIO_FSEL_BASE_BIT 5
`define GPIO_FSEL_W 5

// Access code for an idle read or write port
`define ACC_NONE 2'b11

`endif

//--- read_buffer.sv
// Read hold register that keeps peripheral data until the core has taken it
`include "periph_defines.svh"

module read_buffer
    import bus_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  acc_t  i_read_n,
    input  data_t i_rdata_src,
    input  logic  i_ready_src,
    input  logic  i_read_complete,
    output data_t o_data_out,
    output logic  o_read_ready
);

    logic  read_req;
    logic  capture;
    logic  hold_q;
    logic  ready_q;
    data_t data_q;

    assign read_req = (i_read_n != `ACC_NONE);

    // New data is only taken while nothing is held for the core
    assign capture = read_req && i_ready_src && !hold_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_q  <= 1'b0;
            ready_q <= 1'b0;
        end else begin
            if (i_read_complete) begin
                hold_q <= 1'b0;
            end
            if (capture) begin
                hold_q <= 1'b1;
            end
            // Ready follows the registered data by design
            ready_q <= read_req && i_ready_src;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            data_q <= i_rdata_src;
        end
    end

    assign o_data_out   = data_q;
    assign o_read_ready = ready_q;

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the peripheral wrapper testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/100ps \
    -f src.f --top-module tb_periph -o sim_periph

./obj_dir/sim_periph > sim.log 2>&1
cat sim.log

if grep -q "Errors found" sim.log; then
    exit 1
fi
exit 0

//--- src.f
+incdir+.
bus_pkg.sv
gpio_pkg.sv
periph_decode.sv
read_buffer.sv
gpio_regs.sv
tinyqv_periph_top.sv
tb_periph.sv

//--- tb_periph.sv
// Table-driven testbench for the peripheral wrapper with GPIO, decoder and read hold
`include "periph_defines.svh"

module tb_periph
    import bus_pkg::*;
    import gpio_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD    = 4;
    localparam int RESET_CYCLES  = 16;
    localparam int NUM_ENTRIES   = 34;
    localparam int READ_WAIT_MAX = 8;
    localparam int WATCHDOG_NS   = (NUM_ENTRIES * 10 + RESET_CYCLES) * CLK_PERIOD;

    localparam logic [1:0] OP_WRITE     = 2'd0;
    localparam logic [1:0] OP_READ      = 2'd1;
    localparam logic [1:0] OP_READ_HELD = 2'd2;
    // Where the expected read value comes from
    localparam logic [1:0] EXP_CONST    = 2'd0;
    localparam logic [1:0] EXP_UI       = 2'd1;
    localparam logic [1:0] EXP_HELD     = 2'd2;
    localparam acc_t       ACC_WORD     = 2'b10;

    typedef struct packed {
        logic [1:0] op;
        addr_t      addr;
        data_t      wdata;
        logic [1:0] kind;
        data_t      exp_data;
        pins_t      exp_uo;
        logic       new_ui;
    } entry_t;

    logic  clk;
    logic  rst_n;
    pins_t i_ui_in;
    pins_t o_uo_out;
    addr_t i_addr;
    data_t i_data_in;
    acc_t  i_data_write_n;
    acc_t  i_data_read_n;
    data_t o_data_out;
    logic  o_data_ready;
    logic  i_data_read_complete;

    entry_t      entries [NUM_ENTRIES];
    int          entry_count = 0;
    int          error_count = 0;
    int          fail_count = 0;
    int          test_count = 0;
    logic [31:0] lfsr_q = 32'h7ecd_67fd;
    data_t       prev_read = '0;

    tinyqv_periph_top dut (
        .clk                  (clk),
        .rst_n                (rst_n),
        .i_ui_in              (i_ui_in),
        .o_uo_out             (o_uo_out),
        .i_addr               (i_addr),
        .i_data_in            (i_data_in),
        .i_data_write_n       (i_data_write_n),
        .i_data_read_n        (i_data_read_n),
        .o_data_out           (o_data_out),
        .o_data_ready         (o_data_ready),
        .i_data_read_complete (i_data_read_complete)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Galois form with taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        logic [31:0] n;
        n = s >> 1;
        if (s[0]) begin
            n = n ^ 32'h8020_0003;
        end
        return n;
    endfunction

    task automatic draw_pins(output pins_t v);
        for (int i = 0; i < `GPIO_NUM_PINS; i++) begin
            v[i] = lfsr_q[0];
            lfsr_q = lfsr_step(lfsr_q);
        end
    endtask

    task automatic add_entry(input logic [1:0] op, input addr_t addr, input data_t wdata,
                             input logic [1:0] kind, input data_t exp_data,
                             input pins_t exp_uo, input logic new_ui);
        if (entry_count < NUM_ENTRIES) begin
            entries[entry_count] = '{op, addr, wdata, kind, exp_data, exp_uo, new_ui};
        end
        entry_count++;
    endtask

    task automatic build_table();
        // Reset values of the select bank and the output register
        add_entry(OP_READ, 11'h060, 32'h0, EXP_CONST, 32'h2, 8'h00, 1'b0);
        add_entry(OP_READ, 11'h064, 32'h0, EXP_CONST, 32'h2, 8'h00, 1'b0);
        for (int p = 2; p < `GPIO_NUM_PINS; p++) begin
            add_entry(OP_READ, addr_t'(11'h060 + 4 * p), 32'h0, EXP_CONST, 32'h1, 8'h00, 1'b0);
        end
        add_entry(OP_READ, 11'h040, 32'h0, EXP_CONST, 32'h0, 8'h00, 1'b0);
        // Output register with pins 0 and 1 still on the absent UART
        add_entry(OP_WRITE, 11'h040, 32'hffff_ffa7, EXP_CONST, 32'h0, 8'ha4, 1'b0);
        add_entry(OP_READ, 11'h040, 32'h0, EXP_CONST, 32'ha7, 8'ha4, 1'b0);
        add_entry(OP_READ, 11'h044, 32'h0, EXP_UI, 32'h0, 8'ha4, 1'b1);
        // Function selects
        add_entry(OP_WRITE, 11'h060, 32'h1, EXP_CONST, 32'h0, 8'ha5, 1'b0);
        add_entry(OP_WRITE, 11'h064, 32'hffff_ffe1, EXP_CONST, 32'h0, 8'ha7, 1'b0);
        add_entry(OP_READ, 11'h064, 32'h0, EXP_CONST, 32'h1, 8'ha7, 1'b0);
        add_entry(OP_WRITE, 11'h07c, 32'h0, EXP_CONST, 32'h0, 8'h27, 1'b0);
        add_entry(OP_WRITE, 11'h074, 32'h11, EXP_CONST, 32'h0, 8'h07, 1'b0);
        add_entry(OP_WRITE, 11'h068, 32'h3, EXP_CONST, 32'h0, 8'h03, 1'b0);
        add_entry(OP_READ, 11'h074, 32'h0, EXP_CONST, 32'h11, 8'h03, 1'b0);
        add_entry(OP_READ, 11'h068, 32'h0, EXP_CONST, 32'h3, 8'h03, 1'b0);
        add_entry(OP_READ, 11'h07c, 32'h0, EXP_CONST, 32'h0, 8'h03, 1'b0);
        // Empty user slot, unused offset and simple space
        add_entry(OP_READ, 11'h0c0, 32'h0, EXP_CONST, 32'h0, 8'h03, 1'b0);
        add_entry(OP_READ, 11'h048, 32'h0, EXP_CONST, 32'h0, 8'h03, 1'b0);
        add_entry(OP_READ, 11'h410, 32'h0, EXP_CONST, 32'h0, 8'h03, 1'b0);
        add_entry(OP_READ, 11'h440, 32'h0, EXP_CONST, 32'h0, 8'h03, 1'b0);
        add_entry(OP_WRITE, 11'h0c0, 32'hff, EXP_CONST, 32'h0, 8'h03, 1'b0);
        add_entry(OP_WRITE, 11'h440, 32'hff, EXP_CONST, 32'h0, 8'h03, 1'b0);
        add_entry(OP_WRITE, 11'h048, 32'hff, EXP_CONST, 32'h0, 8'h03, 1'b0);
        add_entry(OP_READ, 11'h040, 32'h0, EXP_CONST, 32'ha7, 8'h03, 1'b0);
        add_entry(OP_READ, 11'h060, 32'h0, EXP_CONST, 32'h1, 8'h03, 1'b0);
        // Hold register keeps the first value until read complete
        add_entry(OP_READ_HELD, 11'h044, 32'h0, EXP_UI, 32'h0, 8'h03, 1'b1);
        add_entry(OP_READ_HELD, 11'h044, 32'h0, EXP_HELD, 32'h0, 8'h03, 1'b1);
        add_entry(OP_READ, 11'h044, 32'h0, EXP_HELD, 32'h0, 8'h03, 1'b0);
        add_entry(OP_READ, 11'h044, 32'h0, EXP_UI, 32'h0, 8'h03, 1'b0);
    endtask

    function automatic string op_name(input logic [1:0] op);
        case (op)
            OP_WRITE: return "write";
            OP_READ:  return "read";
            default:  return "read-held";
        endcase
    endfunction

    // Called 1 ns after a rising edge, returns at the same point of a later cycle
    task automatic run_entry(input int idx);
        entry_t e;
        pins_t  ui_val;
        data_t  expected;
        int     cycles;
        int     errs_before;
        e = entries[idx];
        errs_before = error_count;
        if (e.new_ui) begin
            draw_pins(ui_val);
            i_ui_in = ui_val;
        end
        i_addr = e.addr;
        if (e.op == OP_WRITE) begin
            i_data_in = e.wdata;
            i_data_write_n = ACC_WORD;
            #1;
            if (o_data_ready !== 1'b1) begin
                $display("mismatch at %0d ns: no ready in write cycle to 0x%h", $time, e.addr);
                error_count++;
            end
            @(posedge clk);
            #1;
            i_data_write_n = `ACC_NONE;
        end else begin
            i_data_read_n = ACC_WORD;
            #1;
            // Ready comes from a register, so it is still low as the read begins
            if (o_data_ready !== 1'b0) begin
                $display("mismatch at %0d ns: ready already high as read 0x%h begins",
                         $time, e.addr);
                error_count++;
            end
            cycles = 0;
            do begin
                @(posedge clk);
                #1;
                cycles++;
            end while (o_data_ready !== 1'b1 && cycles < READ_WAIT_MAX);
            case (e.kind)
                EXP_UI:   expected = {{(`PERI_DATA_W - `GPIO_NUM_PINS){1'b0}}, i_ui_in};
                EXP_HELD: expected = prev_read;
                default:  expected = e.exp_data;
            endcase
            prev_read = expected;
            if (o_data_ready !== 1'b1) begin
                $display("read from 0x%h never got ready within %0d cycles", e.addr, cycles);
                error_count++;
            end else begin
                if (cycles != 1) begin
                    $display("mismatch at %0d ns: ready after %0d cycles, expected 1",
                             $time, cycles);
                    error_count++;
                end
                if (o_data_out !== expected) begin
                    $display("mismatch at %0d ns: read 0x%h got 0x%h, expected 0x%h",
                             $time, e.addr, o_data_out, expected);
                    error_count++;
                end
            end
            i_data_read_n = `ACC_NONE;
            i_data_read_complete = (e.op == OP_READ);
            @(posedge clk);
            #1;
            i_data_read_complete = 1'b0;
        end
        @(posedge clk);
        #1;
        if (o_uo_out !== e.exp_uo) begin
            $display("mismatch at %0d ns: uo_out 0x%h, expected 0x%h",
                     $time, o_uo_out, e.exp_uo);
            error_count++;
        end
        test_count++;
        if (error_count != errs_before) begin
            fail_count++;
        end
        $display("test %0d %s 0x%h: %s", idx + 1, op_name(e.op), e.addr,
                 (error_count == errs_before) ? "pass" : "fail");
    endtask

    initial begin
        rst_n = 1'b0;
        i_ui_in = '0;
        i_addr = '0;
        i_data_in = '0;
        i_data_write_n = `ACC_NONE;
        i_data_read_n = `ACC_NONE;
        i_data_read_complete = 1'b0;
        build_table();
        if (entry_count != NUM_ENTRIES) begin
            $display("stimulus table holds %0d entries instead of %0d", entry_count, NUM_ENTRIES);
            error_count++;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        @(posedge clk);
        #1;
        test_count++;
        if (o_data_ready !== 1'b0 || o_uo_out !== 8'h00) begin
            $display("mismatch at %0d ns: after reset ready %b uo_out 0x%h",
                     $time, o_data_ready, o_uo_out);
            error_count++;
            fail_count++;
            $display("test 0 reset values: fail");
        end else begin
            $display("test 0 reset values: pass");
        end
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            run_entry(i);
        end
        $display("%0d tests run, %0d failed, %0d errors", test_count, fail_count, error_count);
        if (error_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Errors found");
        $finish;
    end

endmodule

//--- tinyqv_periph_top.sv
// Peripheral wrapper top connecting the core bus to the decoder, GPIO and read buffer
`include "periph_defines.svh"

module tinyqv_periph_top
    import bus_pkg::*;
    import gpio_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  pins_t i_ui_in,
    output pins_t o_uo_out,
    input  addr_t i_addr,
    input  data_t i_data_in,
    input  acc_t  i_data_write_n,
    input  acc_t  i_data_read_n,
    output data_t o_data_out,
    output logic  o_data_ready,
    input  logic  i_data_read_complete
);

    slot_sel_t user_sel;
    data_t     gpio_rdata;
    data_t     rdata_src;
    logic      ready_src;
    logic      read_ready;
    acc_t      gpio_write_n;

    periph_decode u_decode (
        .i_addr       (i_addr),
        .i_gpio_rdata (gpio_rdata),
        .o_user_sel   (user_sel),
        .o_rdata_src  (rdata_src),
        .o_ready_src  (ready_src)
    );

    // Writes reach GPIO only while its slot is addressed
    assign gpio_write_n = i_data_write_n | {2{~user_sel[`PERI_SLOT_GPIO]}};

    gpio_regs u_gpio (
        .clk       (clk),
        .rst_n     (rst_n),
        .i_ofs     (i_addr[`PERI_USER_SLOT_LSB-1:0]),
        .i_wdata   (i_data_in),
        .i_write_n (gpio_write_n),
        .i_ui_in   (i_ui_in),
        .o_rdata   (gpio_rdata),
        .o_uo_out  (o_uo_out)
    );

    read_buffer u_rbuf (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_read_n        (i_data_read_n),
        .i_rdata_src     (rdata_src),
        .i_ready_src     (ready_src),
        .i_read_complete (i_data_read_complete),
        .o_data_out      (o_data_out),
        .o_read_ready    (read_ready)
    );

    // Writes are acknowledged in the cycle they are presented
    assign o_data_ready = read_ready || (i_data_write_n != `ACC_NONE);

endmodule
